// File: src/backend_pkg.sv
// shared widths, opcodes and record types for the RV64 back end
// imported by every block that builds or decodes an operation

package backend_pkg;

    localparam int XLEN           = 64;
    localparam int PC_W           = 64;
    localparam int INST_W         = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int IQ_DEPTH       = 4;   // also the sender's initial credits
    localparam int IQ_PTR_W       = $clog2(IQ_DEPTH);
    localparam int IQ_CNT_W       = $clog2(IQ_DEPTH + 1);
    localparam int RETIRE_CREDITS = 2;
    localparam int CREDIT_W       = $clog2(RETIRE_CREDITS + 1);
    localparam int DMEM_WORDS     = 256;
    localparam int DMEM_IDX_W     = 8;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SRA   = 4'd7,
        OP_SLT   = 4'd8,
        OP_LOAD  = 4'd9,
        OP_STORE = 4'd10
    } alu_op_e;

    // funct3 encoding, bit 2 marks the unsigned loads
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_size_e;

    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [INST_W-1:0]     inst;
        alu_op_e               op;
        ls_size_e              ls_size;
        logic [XLEN-1:0]       src_a;
        logic [XLEN-1:0]       src_b;
        logic [XLEN-1:0]       imm;
        logic                  rd_ena;
        logic [REG_ADDR_W-1:0] rd_addr;
    } issue_op_t;

    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [INST_W-1:0]     inst;
        alu_op_e               op;
        ls_size_e              ls_size;
        logic                  rd_ena;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_data;   // alu result or store data
        logic [XLEN-1:0]       ls_addr;
        logic                  valid;
    } ex_mem_t;

    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [INST_W-1:0]     inst;
        logic                  rd_ena;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rd_data;
    } retire_t;

endpackage

// File: src/issue_queue.sv
`timescale 1ns/1ps
// input FIFO for decoded operations, returns one credit per popped entry
// the sender starts out with IQ_DEPTH credits

module issue_queue (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   op_valid_i,
    input  backend_pkg::issue_op_t op_i,
    input  logic                   hold_i,
    output logic                   head_valid_o,
    output backend_pkg::issue_op_t head_o,
    output logic                   credit_o
);
    import backend_pkg::*;

    issue_op_t           entries [IQ_DEPTH];
    logic [IQ_PTR_W-1:0] wr_ptr_q;
    logic [IQ_PTR_W-1:0] rd_ptr_q;
    logic [IQ_CNT_W-1:0] count_q;
    logic                pop;

    assign head_valid_o = (count_q != '0);
    assign head_o       = entries[rd_ptr_q];
    assign pop          = head_valid_o && !hold_i;   // head moves into ex_mem

    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            entries[wr_ptr_q] <= op_i;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_o <= 1'b0;
        end else begin
            if (op_valid_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({op_valid_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            credit_o <= pop;   // one cycle after the pop
        end
    end

    // sender may only push while holding a credit
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(op_valid_i && (count_q == IQ_CNT_W'(IQ_DEPTH)))
    ) else $error("issue_queue: push into a full queue");

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps
// execute stage, alu and load/store address for the queue head
// purely combinational, result is captured by ex_mem

module exec_unit (
    input  logic                   head_valid_i,
    input  backend_pkg::issue_op_t head_i,
    output backend_pkg::ex_mem_t   ex_o
);
    import backend_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] agu_addr;
    logic            is_mem_op;

    assign src_a     = head_i.src_a;
    assign src_b     = head_i.src_b;
    assign shamt     = src_b[5:0];   // rv64 shift amount
    assign agu_addr  = src_a + head_i.imm;
    assign is_mem_op = (head_i.op == OP_LOAD) || (head_i.op == OP_STORE);

    always_comb begin
        case (head_i.op)
            OP_ADD:  alu_res = src_a + src_b;
            OP_SUB:  alu_res = src_a - src_b;
            OP_AND:  alu_res = src_a & src_b;
            OP_OR:   alu_res = src_a | src_b;
            OP_XOR:  alu_res = src_a ^ src_b;
            OP_SLL:  alu_res = src_a << shamt;
            OP_SRL:  alu_res = src_a >> shamt;
            OP_SRA:  alu_res = $signed(src_a) >>> shamt;
            OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, ($signed(src_a) < $signed(src_b))};
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        ex_o.pc      = head_i.pc;
        ex_o.inst    = head_i.inst;
        ex_o.op      = head_i.op;
        ex_o.ls_size = head_i.ls_size;
        ex_o.rd_ena  = head_i.rd_ena;
        ex_o.rd_addr = head_i.rd_addr;
        ex_o.rd_data = is_mem_op ? src_b : alu_res;   // src_b is store data
        ex_o.ls_addr = agu_addr;
        ex_o.valid   = head_valid_i;
    end

    // decode on the sender side must never ask a store to write a register
    always_comb begin
        a_store_no_rd: assert final (
            !(head_valid_i && (head_i.op == OP_STORE) && head_i.rd_ena)
        ) else $error("exec_unit: store with rd_ena set");
    end

endmodule

// File: src/ex_mem.sv
`timescale 1ns/1ps
// execute/memory pipeline register
// holds its contents while the retire side stalls

module ex_mem (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 hold_i,
    input  backend_pkg::ex_mem_t ex_i,
    output backend_pkg::ex_mem_t mem_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_o <= '0;
        end else if (!hold_i) begin
            mem_o <= ex_i;   // bubble when the queue is empty
        end
    end

    // a held operation must reach the memory stage unchanged
    a_stable_on_hold: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        hold_i |=> $stable(mem_o)
    ) else $error("ex_mem: contents changed under hold");

endmodule

// File: src/mem_stage.sv
`timescale 1ns/1ps
// memory stage, on-chip data memory with byte-lane stores and extending loads
// forms the retire record handed to commit_port

module mem_stage (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 hold_i,
    input  backend_pkg::ex_mem_t mem_i,
    output logic                 ret_valid_o,
    output backend_pkg::retire_t ret_o
);
    import backend_pkg::*;

    logic [XLEN-1:0]       dmem [DMEM_WORDS];
    logic [DMEM_IDX_W-1:0] word_idx;
    logic [2:0]            byte_off;
    logic [7:0]            size_mask;
    logic [7:0]            byte_en;
    logic [XLEN-1:0]       rd_word;
    logic [XLEN-1:0]       lane_data;
    logic [XLEN-1:0]       load_data;
    logic [XLEN-1:0]       st_data;
    logic                  is_load;
    logic                  st_en;

    assign word_idx = mem_i.ls_addr[DMEM_IDX_W+2:3];

    // offset aligned down to the access size
    always_comb begin
        case (mem_i.ls_size[1:0])
            2'b00: begin
                byte_off  = mem_i.ls_addr[2:0];
                size_mask = 8'h01;
            end
            2'b01: begin
                byte_off  = {mem_i.ls_addr[2:1], 1'b0};
                size_mask = 8'h03;
            end
            2'b10: begin
                byte_off  = {mem_i.ls_addr[2], 2'b00};
                size_mask = 8'h0f;
            end
            default: begin
                byte_off  = 3'b000;
                size_mask = 8'hff;
            end
        endcase
    end

    assign byte_en   = size_mask << byte_off;
    assign st_data   = mem_i.rd_data << {byte_off, 3'b000};
    assign rd_word   = dmem[word_idx];
    assign lane_data = rd_word >> {byte_off, 3'b000};

    always_comb begin
        case (mem_i.ls_size)
            LS_B:    load_data = {{(XLEN-8){lane_data[7]}}, lane_data[7:0]};
            LS_H:    load_data = {{(XLEN-16){lane_data[15]}}, lane_data[15:0]};
            LS_W:    load_data = {{(XLEN-32){lane_data[31]}}, lane_data[31:0]};
            LS_BU:   load_data = {{(XLEN-8){1'b0}}, lane_data[7:0]};
            LS_HU:   load_data = {{(XLEN-16){1'b0}}, lane_data[15:0]};
            LS_WU:   load_data = {{(XLEN-32){1'b0}}, lane_data[31:0]};
            default: load_data = lane_data;   // LS_D
        endcase
    end

    assign is_load = (mem_i.op == OP_LOAD);
    assign st_en   = mem_i.valid && (mem_i.op == OP_STORE) && !hold_i;   // once per store

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < DMEM_WORDS; w++) begin
                dmem[w] <= '0;
            end
        end else if (st_en) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_en[b]) begin
                    dmem[word_idx][b*8 +: 8] <= st_data[b*8 +: 8];
                end
            end
        end
    end

    assign ret_valid_o   = mem_i.valid;
    assign ret_o.pc      = mem_i.pc;
    assign ret_o.inst    = mem_i.inst;
    assign ret_o.rd_ena  = mem_i.rd_ena;
    assign ret_o.rd_addr = mem_i.rd_addr;
    assign ret_o.rd_data = is_load ? load_data : mem_i.rd_data;

endmodule

// File: src/commit_port.sv
`timescale 1ns/1ps
// retirement output register with credit flow control toward the consumer
// raises hold for the whole pipe when a record is stuck without a credit

module commit_port (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 ret_valid_i,
    input  backend_pkg::retire_t ret_i,
    input  logic                 retire_credit_i,
    output logic                 hold_o,
    output logic                 retire_valid_o,
    output backend_pkg::retire_t retire_o
);
    import backend_pkg::*;

    retire_t             rec_q;
    logic                full_q;
    logic [CREDIT_W-1:0] credits_q;
    logic                send;
    logic                load;

    assign send           = full_q && (credits_q != '0);
    assign hold_o         = full_q && (credits_q == '0);
    assign load           = ret_valid_i && (!full_q || send);
    assign retire_valid_o = send;
    assign retire_o       = rec_q;

    always_ff @(posedge clk) begin
        if (load) begin
            rec_q <= ret_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q    <= 1'b0;
            credits_q <= CREDIT_W'(RETIRE_CREDITS);
        end else begin
            if (load) begin
                full_q <= 1'b1;
            end else if (send) begin
                full_q <= 1'b0;
            end
            // returned credit may arrive in the sending cycle
            credits_q <= credits_q + CREDIT_W'(retire_credit_i) - CREDIT_W'(send);
        end
    end

    // consumer never returns more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        credits_q <= CREDIT_W'(RETIRE_CREDITS)
    ) else $error("commit_port: credit counter overflow");

endmodule

// File: src/backend_top.sv
`timescale 1ns/1ps
// back end top, queue -> execute -> ex_mem -> memory -> commit
// credit handshakes on both the operation input and the retire output

module backend_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   op_valid_i,
    input  backend_pkg::issue_op_t op_i,
    output logic                   op_credit_o,
    output logic                   retire_valid_o,
    output backend_pkg::retire_t   retire_o,
    input  logic                   retire_credit_i
);
    import backend_pkg::*;

    logic      head_valid;
    issue_op_t head_op;
    ex_mem_t   ex_op;
    ex_mem_t   mem_op;
    logic      ret_valid;
    retire_t   ret_rec;
    logic      hold;   // single stall source, from commit_port

    issue_queue i_issue_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .op_valid_i   (op_valid_i),
        .op_i         (op_i),
        .hold_i       (hold),
        .head_valid_o (head_valid),
        .head_o       (head_op),
        .credit_o     (op_credit_o)
    );

    exec_unit i_exec_unit (
        .head_valid_i (head_valid),
        .head_i       (head_op),
        .ex_o         (ex_op)
    );

    ex_mem i_ex_mem (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .hold_i  (hold),
        .ex_i    (ex_op),
        .mem_o   (mem_op)
    );

    mem_stage i_mem_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .hold_i      (hold),
        .mem_i       (mem_op),
        .ret_valid_o (ret_valid),
        .ret_o       (ret_rec)
    );

    commit_port i_commit_port (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .ret_valid_i     (ret_valid),
        .ret_i           (ret_rec),
        .retire_credit_i (retire_credit_i),
        .hold_o          (hold),
        .retire_valid_o  (retire_valid_o),
        .retire_o        (retire_o)
    );

endmodule

// File: testbench/backend_tb.sv
`timescale 1ns/1ps
// directed testbench for backend_top with a credit sender and a credit consumer
// expected retire records come from a reference model of the execute and memory rules

module backend_tb;
    import backend_pkg::*;

    logic            clk;
    logic            rst_n_i;
    logic            op_valid_i;
    issue_op_t       op_i;
    logic            op_credit_o;
    logic            retire_valid_o;
    retire_t         retire_o;
    logic            retire_credit_i;

    logic [XLEN-1:0] model_mem [DMEM_WORDS];
    retire_t         exp_q [$];
    int              send_credits;
    int              owed_credits;   // consumer credits not yet handed back
    logic            withhold;
    int              accepted;
    int              credit_pulses;
    int              retired;
    int              value_errs;
    int              other_errs;
    logic [PC_W-1:0] next_pc;

    backend_top i_backend_top (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .op_valid_i      (op_valid_i),
        .op_i            (op_i),
        .op_credit_o     (op_credit_o),
        .retire_valid_o  (retire_valid_o),
        .retire_o        (retire_o),
        .retire_credit_i (retire_credit_i)
    );

    always #20 clk = ~clk;

    // consumer returns one credit per record unless withholding
    always @(posedge clk) begin
        #2;
        if (!withhold && owed_credits > 0) begin
            retire_credit_i = 1'b1;
            owed_credits--;
        end else begin
            retire_credit_i = 1'b0;
        end
    end

    always @(negedge clk) begin
        if (rst_n_i) begin
            if (op_credit_o) begin
                send_credits++;
                credit_pulses++;
            end
            if (retire_valid_o) begin
                retired++;
                owed_credits++;
                check_record(retire_o);
            end
        end
    end

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_record(input retire_t got);
        retire_t exp;
        if (exp_q.size() == 0) begin
            $display("retire record for pc %h arrived with nothing outstanding", got.pc);
            other_errs++;
        end else begin
            exp = exp_q.pop_front();
            compare_field("retire_o.pc", got.pc, exp.pc);
            compare_field("retire_o.inst", 64'(got.inst), 64'(exp.inst));
            compare_field("retire_o.rd_ena", 64'(got.rd_ena), 64'(exp.rd_ena));
            compare_field("retire_o.rd_addr", 64'(got.rd_addr), 64'(exp.rd_addr));
            compare_field("retire_o.rd_data", got.rd_data, exp.rd_data);
        end
    endtask

    // reference model applied in issue order
    function automatic retire_t model_op(input issue_op_t op);
        retire_t         r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] val;
        int              nb;
        int              off;
        a    = op.src_a;
        b    = op.src_b;
        addr = a + op.imm;
        nb   = 1 << op.ls_size[1:0];
        off  = int'(addr[2:0]) & ~(nb - 1);
        val  = '0;
        case (op.op)
            OP_ADD:  val = a + b;
            OP_SUB:  val = a - b;
            OP_AND:  val = a & b;
            OP_OR:   val = a | b;
            OP_XOR:  val = a ^ b;
            OP_SLL:  val = a << b[5:0];
            OP_SRL:  val = a >> b[5:0];
            OP_SRA:  val = $signed(a) >>> b[5:0];
            OP_SLT:  val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_STORE: begin
                for (int i = 0; i < nb; i++) begin
                    model_mem[addr[10:3]][(off + i) * 8 +: 8] = b[i * 8 +: 8];
                end
                val = b;
            end
            OP_LOAD: begin
                for (int i = 0; i < nb; i++) begin
                    val[i * 8 +: 8] = model_mem[addr[10:3]][(off + i) * 8 +: 8];
                end
                if (!op.ls_size[2] && nb < 8 && val[nb * 8 - 1]) begin
                    val = val | ~((64'd1 << (nb * 8)) - 64'd1);
                end
            end
            default: val = '0;
        endcase
        r.pc      = op.pc;
        r.inst    = op.inst;
        r.rd_ena  = op.rd_ena;
        r.rd_addr = op.rd_addr;
        r.rd_data = val;
        return r;
    endfunction

    function automatic logic [63:0] rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic issue_op_t make_op(input alu_op_e code, input ls_size_e sz,
                                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                          input logic [XLEN-1:0] imm);
        issue_op_t op;
        op.pc      = next_pc;
        op.inst    = $urandom;
        op.op      = code;
        op.ls_size = sz;
        op.src_a   = a;
        op.src_b   = b;
        op.imm     = imm;
        op.rd_ena  = (code != OP_STORE);
        op.rd_addr = 5'($urandom_range(1, 31));
        next_pc    = next_pc + 64'd4;
        return op;
    endfunction

    function automatic issue_op_t random_op();
        alu_op_e         code;
        ls_size_e        sz;
        logic [XLEN-1:0] addr;
        code = alu_op_e'($urandom_range(0, 10));
        sz   = ls_size_e'($urandom_range(0, 6));
        addr = {56'd0, 5'($urandom_range(0, 3)), 3'($urandom)};   // a few shared words
        if (code == OP_STORE) begin
            sz = ls_size_e'({1'b0, sz[1:0]});
        end
        if (code == OP_LOAD || code == OP_STORE) begin
            return make_op(code, sz, addr, rand_word(), '0);
        end
        return make_op(code, sz, rand_word(), rand_word(), '0);
    endfunction

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic set_withhold(input logic v);
        @(negedge clk);
        withhold = v;
        @(posedge clk);
        #2;
    endtask

    task automatic send_op(input issue_op_t op);
        int waited;
        waited = 0;
        while (send_credits == 0 && waited < 200) begin
            step_cycles(1);
            waited++;
        end
        if (send_credits == 0) begin
            $display("sender timed out waiting for an input credit");
            other_errs++;
        end else begin
            op_valid_i = 1'b1;
            op_i       = op;
            send_credits--;
            accepted++;
            exp_q.push_back(model_op(op));
            step_cycles(1);
            op_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || owed_credits != 0 || send_credits != IQ_DEPTH)
               && waited < 300) begin
            step_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0 || send_credits != IQ_DEPTH) begin
            $display("pipeline did not drain, %0d records still missing", exp_q.size());
            other_errs++;
            exp_q.delete();
        end
        step_cycles(2);   // last credit reaches commit_port
    endtask

    task automatic alu_op_sweep();
        alu_op_e code;
        for (int c = 0; c <= 8; c++) begin
            code = alu_op_e'(c);
            for (int k = 0; k < 6; k++) begin
                send_op(make_op(code, LS_D, rand_word(), rand_word(), rand_word()));
            end
            // shift amount above 31 then negative against positive
            send_op(make_op(code, LS_D, 64'h8000_0000_0000_00f1, 64'd37 + 64'(c), '0));
            send_op(make_op(code, LS_D, 64'hffff_ffff_ffff_fffb, 64'd3, '0));
        end
        wait_drain();
    endtask

    task automatic load_store_sweep();
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] imm;
        int              nb;
        for (int s = 0; s < 4; s++) begin
            nb = 1 << s;
            for (int off = 0; off < 8; off += nb) begin
                addr = {53'd0, 8'($urandom_range(0, 3)), 3'(off)};
                imm  = 64'($urandom_range(0, 64)) - 64'd32;
                send_op(make_op(OP_STORE, ls_size_e'(s), addr - imm, rand_word(), imm));
                send_op(make_op(OP_LOAD, ls_size_e'(s), addr - imm, '0, imm));
                if (s < 3) begin
                    send_op(make_op(OP_LOAD, ls_size_e'(s + 4), addr, '0, '0));
                end
                send_op(make_op(OP_LOAD, LS_D, addr, '0, '0));   // neighbouring lanes intact
            end
        end
        wait_drain();
    endtask

    task automatic latency_probe();
        int credit_at;
        int retire_at;
        credit_at = 0;
        retire_at = 0;
        send_op(make_op(OP_ADD, LS_D, rand_word(), rand_word(), '0));
        for (int cyc = 1; cyc <= 20 && retire_at == 0; cyc++) begin
            @(negedge clk);
            if (op_credit_o && credit_at == 0) begin
                credit_at = cyc;
            end
            if (retire_valid_o) begin
                retire_at = cyc;
            end
        end
        step_cycles(1);
        if (credit_at != 2) begin
            $display("op_credit_o pulsed %0d cycles after acceptance, expected 2", credit_at);
            other_errs++;
        end
        if (retire_at != 3) begin
            $display("retire_valid_o pulsed %0d cycles after acceptance, expected 3", retire_at);
            other_errs++;
        end
        wait_drain();
    endtask

    task automatic backpressure_run();
        int ret_start;
        int pulse_start;
        ret_start   = retired;
        pulse_start = credit_pulses;
        set_withhold(1'b1);
        fork
            begin
                for (int k = 0; k < 10; k++) begin
                    send_op(random_op());
                end
            end
            begin
                step_cycles(24);
                if (retired - ret_start > RETIRE_CREDITS) begin
                    $display("%0d records sent without credits", retired - ret_start);
                    other_errs++;
                end
                // stalled pipe pops only the retired records plus commit and ex_mem
                if (credit_pulses - pulse_start > RETIRE_CREDITS + 2) begin
                    $display("op_credit_o kept pulsing while the retire side was stalled");
                    other_errs++;
                end
                set_withhold(1'b0);
            end
        join
        wait_drain();
    endtask

    task automatic credit_burst();
        int acc_start;
        int pulse_start;
        acc_start   = accepted;
        pulse_start = credit_pulses;
        for (int k = 0; k < 40; k++) begin
            send_op(random_op());
        end
        wait_drain();
        if ((credit_pulses - pulse_start) != (accepted - acc_start)) begin
            $display("error op_credit_o: got %h pulses expected %h",
                     credit_pulses - pulse_start, accepted - acc_start);
            value_errs++;
        end
    endtask

    initial begin
        void'($urandom(32'h525c));
        clk             = 1'b0;
        rst_n_i         = 1'b0;
        op_valid_i      = 1'b0;
        op_i            = '0;
        retire_credit_i = 1'b0;
        withhold        = 1'b0;
        send_credits    = IQ_DEPTH;
        owed_credits    = 0;
        accepted        = 0;
        credit_pulses   = 0;
        retired         = 0;
        value_errs      = 0;
        other_errs      = 0;
        next_pc         = 64'h8000_0000;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            model_mem[w] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk);
        if (op_credit_o || retire_valid_o) begin
            $display("credit or retire output active right after reset");
            other_errs++;
        end
        step_cycles(1);
        alu_op_sweep();
        latency_probe();
        load_store_sweep();
        backpressure_run();
        credit_burst();
        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: backend_top.f
src/backend_pkg.sv
src/issue_queue.sv
src/exec_unit.sv
src/ex_mem.sv
src/mem_stage.sv
src/commit_port.sv
src/backend_top.sv
testbench/backend_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the back end testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f backend_top.f \
    --top-module backend_tb -o backend_sim \
    && ./obj_dir/backend_sim 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL, no result line"; exit 1; }
echo "PASS"
